// ==== logic/hbm_write_pkg.sv ====
`default_nettype none

package hbm_write_pkg;

    ////////////////////
    // address and length widths
    ////////////////////

    // HBM byte address, 8 GB space
    typedef logic [32:0]  hbm_addr_t;
    // host byte address
    typedef logic [63:0]  dma_addr_t;
    typedef logic [31:0]  byte_len_t;
    // a byte length counted in 64-byte bursts
    typedef logic [25:0]  burst_cnt_t;
    // channel field in the top bits of an A address
    typedef logic [4:0]   channel_t;

    ////////////////////
    // data widths
    ////////////////////

    typedef logic [511:0] dma_word_t;
    typedef logic [255:0] hbm_beat_t;

    ////////////////////
    // constants
    ////////////////////

    localparam int unsigned ENGINE_NUM      = 8;
    localparam int unsigned BURST_BYTES     = 64;
    localparam int unsigned BURST_SHIFT     = 6;
    localparam int unsigned BEATS_PER_BURST = 2;
    localparam int unsigned CHANNEL_LSB     = 28;
    localparam int unsigned BUF_DEPTH       = 16;

    // job sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CMD_B,
        RUN_B,
        CMD_A,
        RUN_A,
        FINISH
    } ctrl_state_t;

    typedef enum logic {
        ADDR_IDLE,
        ADDR_RUN
    } addr_state_t;

endpackage

`default_nettype wire

// ==== logic/hbm_word_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_word_buffer (
    input  wire                           hbm_clk,
    input  wire                           hbm_aresetn,
    input  wire                           in_valid,
    input  wire hbm_write_pkg::dma_word_t in_word,
    output logic                          in_ready,
    output logic                          out_valid,
    output hbm_write_pkg::dma_word_t      out_word,
    input  wire                           out_ready
);
    import hbm_write_pkg::*;

    dma_word_t                    mem [BUF_DEPTH];
    logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
    logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
    logic [$clog2(BUF_DEPTH):0]   count;
    logic                         push;
    logic                         pop;

    assign in_ready  = (count != BUF_DEPTH);
    assign out_valid = (count != 0);
    assign out_word  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge hbm_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy stays within the depth and matches the pointer distance
    a_no_overflow: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        (count <= BUF_DEPTH) && (count[$clog2(BUF_DEPTH)-1:0] == (wr_ptr - rd_ptr)))
        else $error("word buffer occupancy out of step with its pointers");

endmodule

`default_nettype wire

// ==== logic/hbm_beat_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_beat_splitter (
    input  wire                           hbm_clk,
    input  wire                           hbm_aresetn,
    input  wire                           word_valid,
    input  wire hbm_write_pkg::dma_word_t word,
    output logic                          word_ready,
    output logic                          wvalid,
    output hbm_write_pkg::hbm_beat_t      wdata,
    output logic                          wlast,
    input  wire                           wready,
    output logic                          burst_done
);
    import hbm_write_pkg::*;

    dma_word_t word_r;
    logic      busy;
    logic      beat;
    logic      w_fire;
    logic      last_fire;

    assign wvalid    = busy;
    assign wlast     = (beat == 1'(BEATS_PER_BURST - 1));
    assign w_fire    = wvalid && wready;
    assign last_fire = w_fire && wlast;

    // low half first, then the high half
    assign wdata = word_r[beat * $bits(hbm_beat_t) +: $bits(hbm_beat_t)];

    // next word taken in the same cycle as the last beat goes out
    assign word_ready = !busy || last_fire;

    always_ff @(posedge hbm_clk) begin
        if (word_valid && word_ready) begin
            word_r <= word;
        end
    end

    ////////////////////
    // beat sequencing
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            busy       <= 1'b0;
            beat       <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= last_fire;
            if (word_valid && word_ready) begin
                busy <= 1'b1;
                beat <= 1'b0;
            end else if (last_fire) begin
                busy <= 1'b0;
                beat <= 1'b0;
            end else if (w_fire) begin
                beat <= beat + 1'b1;
            end
        end
    end

    a_w_hold: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wlast)))
        else $error("write beat changed while stalled");

endmodule

`default_nettype wire

// ==== logic/hbm_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_addr_gen (
    input  wire                            hbm_clk,
    input  wire                            hbm_aresetn,
    input  wire                            addr_load,
    input  wire                            addr_phase_a,
    input  wire hbm_write_pkg::hbm_addr_t  addr_base,
    input  wire hbm_write_pkg::burst_cnt_t addr_bursts,
    input  wire hbm_write_pkg::burst_cnt_t block_bursts,
    input  wire hbm_write_pkg::hbm_addr_t  stride,
    output logic                           awvalid,
    output hbm_write_pkg::hbm_addr_t       awaddr,
    input  wire                            awready,
    output logic                           addr_finished
);
    import hbm_write_pkg::*;

    addr_state_t state;
    logic        phase_a;
    burst_cnt_t  remaining;
    burst_cnt_t  blk_len;
    burst_cnt_t  blk_idx;
    channel_t    chan;
    hbm_addr_t   pass_base;
    hbm_addr_t   offs;
    hbm_addr_t   stride_r;
    hbm_addr_t   chan_field;
    logic        aw_fire;
    logic        blk_end;

    assign awvalid = (state == ADDR_RUN);
    assign aw_fire = awvalid && awready;

    // only the striped layout wraps into the next channel
    assign blk_end    = phase_a && (blk_idx == burst_cnt_t'(blk_len - 1'b1));
    assign chan_field = phase_a ? (hbm_addr_t'(chan) << CHANNEL_LSB) : hbm_addr_t'(0);
    assign awaddr     = chan_field + pass_base + offs;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            state         <= ADDR_IDLE;
            addr_finished <= 1'b0;
        end else begin
            addr_finished <= 1'b0;
            if ((state == ADDR_IDLE) && addr_load) begin
                state <= ADDR_RUN;
            end else if (aw_fire && (remaining == burst_cnt_t'(1))) begin
                state         <= ADDR_IDLE;
                addr_finished <= 1'b1;
            end
        end
    end

    ////////////////////
    // burst walk
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (addr_load) begin
            phase_a   <= addr_phase_a;
            remaining <= addr_bursts;
            blk_len   <= block_bursts;
            stride_r  <= stride;
            blk_idx   <= '0;
            chan      <= '0;
            pass_base <= addr_base;
            offs      <= '0;
        end else if (aw_fire) begin
            remaining <= remaining - 1'b1;
            if (blk_end) begin
                blk_idx <= '0;
                offs    <= '0;
                // pass base moves on after the last channel
                if (chan == channel_t'(ENGINE_NUM - 1)) begin
                    chan      <= '0;
                    pass_base <= pass_base + stride_r;
                end else begin
                    chan <= chan + 1'b1;
                end
            end else begin
                blk_idx <= blk_idx + 1'b1;
                offs    <= offs + hbm_addr_t'(BURST_BYTES);
            end
        end
    end

    a_aw_hold: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else $error("write address changed while stalled");

endmodule

`default_nettype wire

// ==== logic/hbm_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_write_ctrl (
    input  wire                        hbm_clk,
    input  wire                        hbm_aresetn,
    input  wire                        start,
    input  wire hbm_write_pkg::dma_addr_t  dma_addr_a,
    input  wire hbm_write_pkg::dma_addr_t  dma_addr_b,
    input  wire hbm_write_pkg::byte_len_t  data_a_length,
    input  wire hbm_write_pkg::byte_len_t  data_b_length,
    input  wire hbm_write_pkg::hbm_addr_t  hbm_addr_b,
    input  wire hbm_write_pkg::burst_cnt_t a_block_bursts,
    input  wire hbm_write_pkg::hbm_addr_t  a_stride,
    output logic                       dma_cmd_valid,
    output hbm_write_pkg::dma_addr_t   dma_cmd_address,
    output hbm_write_pkg::byte_len_t   dma_cmd_length,
    input  wire                        dma_cmd_ready,
    output logic                       addr_load,
    output logic                       addr_phase_a,
    output hbm_write_pkg::hbm_addr_t   addr_base,
    output hbm_write_pkg::burst_cnt_t  addr_bursts,
    output hbm_write_pkg::burst_cnt_t  block_bursts,
    output hbm_write_pkg::hbm_addr_t   stride,
    input  wire                        addr_finished,
    input  wire                        burst_done,
    output logic                       write_done
);
    import hbm_write_pkg::*;

    ctrl_state_t state;
    dma_addr_t   job_a_addr;
    byte_len_t   job_a_len;
    hbm_addr_t   job_hbm_b;
    burst_cnt_t  total_bursts;
    burst_cnt_t  bursts_seen;
    burst_cnt_t  bursts_next;
    logic        cmd_fire;
    logic        data_all;

    assign dma_cmd_valid = (state == CMD_B) || (state == CMD_A);
    assign cmd_fire      = dma_cmd_valid && dma_cmd_ready;

    // data side is complete once the count including this pulse hits the total
    assign bursts_next = bursts_seen + burst_cnt_t'(burst_done);
    assign data_all    = (bursts_next == total_bursts);

    ////////////////////
    // job and command registers
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if ((state == IDLE) && start) begin
            job_a_addr      <= dma_addr_a;
            job_a_len       <= data_a_length;
            job_hbm_b       <= hbm_addr_b;
            block_bursts    <= a_block_bursts;
            stride          <= a_stride;
            dma_cmd_address <= dma_addr_b;
            dma_cmd_length  <= data_b_length;
            total_bursts    <= burst_cnt_t'((data_a_length >> BURST_SHIFT) +
                                            (data_b_length >> BURST_SHIFT));
        end else if ((state == RUN_B) && addr_finished) begin
            dma_cmd_address <= job_a_addr;
            dma_cmd_length  <= job_a_len;
        end

        // address generator setup follows the accepted command
        if (cmd_fire) begin
            addr_phase_a <= (state == CMD_A);
            addr_base    <= (state == CMD_A) ? hbm_addr_t'(0) : job_hbm_b;
            addr_bursts  <= burst_cnt_t'(dma_cmd_length >> BURST_SHIFT);
        end
    end

    ////////////////////
    // sequencer
    ////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            state       <= IDLE;
            addr_load   <= 1'b0;
            write_done  <= 1'b0;
            bursts_seen <= '0;
        end else begin
            addr_load   <= cmd_fire;
            write_done  <= 1'b0;
            bursts_seen <= bursts_next;
            case (state)
                IDLE: begin
                    if (start) begin
                        state       <= CMD_B;
                        bursts_seen <= '0;
                    end
                end
                CMD_B: begin
                    if (cmd_fire) begin
                        state <= RUN_B;
                    end
                end
                RUN_B: begin
                    if (addr_finished) begin
                        state <= CMD_A;
                    end
                end
                CMD_A: begin
                    if (cmd_fire) begin
                        state <= RUN_A;
                    end
                end
                RUN_A: begin
                    // addresses done, data may still be draining
                    if (addr_finished && data_all) begin
                        write_done <= 1'b1;
                        state      <= IDLE;
                    end else if (addr_finished) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    if (data_all) begin
                        write_done <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_len_aligned: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        ((state == IDLE) && start) |->
            ((data_a_length[BURST_SHIFT-1:0] == '0) && (data_b_length[BURST_SHIFT-1:0] == '0)))
        else $error("job length is not a whole number of bursts");

    a_cmd_hold: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        (dma_cmd_valid && !dma_cmd_ready) |=>
            (dma_cmd_valid && $stable(dma_cmd_address) && $stable(dma_cmd_length)))
        else $error("DMA command changed while stalled");

endmodule

`default_nettype wire

// ==== logic/hbm_write_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbm_write_top (
    input  wire                            hbm_clk,
    input  wire                            hbm_aresetn,
    // job
    input  wire                            start,
    input  wire hbm_write_pkg::dma_addr_t  dma_addr_a,
    input  wire hbm_write_pkg::dma_addr_t  dma_addr_b,
    input  wire hbm_write_pkg::byte_len_t  data_a_length,
    input  wire hbm_write_pkg::byte_len_t  data_b_length,
    input  wire hbm_write_pkg::hbm_addr_t  hbm_addr_b,
    input  wire hbm_write_pkg::burst_cnt_t a_block_bursts,
    input  wire hbm_write_pkg::hbm_addr_t  a_stride,
    // DMA read command and data
    output wire                            dma_cmd_valid,
    output wire hbm_write_pkg::dma_addr_t  dma_cmd_address,
    output wire hbm_write_pkg::byte_len_t  dma_cmd_length,
    input  wire                            dma_cmd_ready,
    input  wire                            dma_data_valid,
    input  wire hbm_write_pkg::dma_word_t  dma_data,
    output wire                            dma_data_ready,
    // HBM write address and data
    output wire                            awvalid,
    output wire hbm_write_pkg::hbm_addr_t  awaddr,
    input  wire                            awready,
    output wire                            wvalid,
    output wire hbm_write_pkg::hbm_beat_t  wdata,
    output wire                            wlast,
    input  wire                            wready,
    output wire                            write_done
);
    import hbm_write_pkg::*;

    logic       addr_load;
    logic       addr_phase_a;
    hbm_addr_t  addr_base;
    burst_cnt_t addr_bursts;
    burst_cnt_t block_bursts;
    hbm_addr_t  stride;
    logic       addr_finished;
    logic       buf_valid;
    dma_word_t  buf_word;
    logic       buf_ready;
    logic       burst_done;

    hbm_write_ctrl u_ctrl (
        .hbm_clk         (hbm_clk),
        .hbm_aresetn     (hbm_aresetn),
        .start           (start),
        .dma_addr_a      (dma_addr_a),
        .dma_addr_b      (dma_addr_b),
        .data_a_length   (data_a_length),
        .data_b_length   (data_b_length),
        .hbm_addr_b      (hbm_addr_b),
        .a_block_bursts  (a_block_bursts),
        .a_stride        (a_stride),
        .dma_cmd_valid   (dma_cmd_valid),
        .dma_cmd_address (dma_cmd_address),
        .dma_cmd_length  (dma_cmd_length),
        .dma_cmd_ready   (dma_cmd_ready),
        .addr_load       (addr_load),
        .addr_phase_a    (addr_phase_a),
        .addr_base       (addr_base),
        .addr_bursts     (addr_bursts),
        .block_bursts    (block_bursts),
        .stride          (stride),
        .addr_finished   (addr_finished),
        .burst_done      (burst_done),
        .write_done      (write_done)
    );

    hbm_addr_gen u_addr_gen (
        .hbm_clk       (hbm_clk),
        .hbm_aresetn   (hbm_aresetn),
        .addr_load     (addr_load),
        .addr_phase_a  (addr_phase_a),
        .addr_base     (addr_base),
        .addr_bursts   (addr_bursts),
        .block_bursts  (block_bursts),
        .stride        (stride),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .addr_finished (addr_finished)
    );

    // DMA words queue here while the write channel stalls
    hbm_word_buffer u_word_buffer (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn),
        .in_valid    (dma_data_valid),
        .in_word     (dma_data),
        .in_ready    (dma_data_ready),
        .out_valid   (buf_valid),
        .out_word    (buf_word),
        .out_ready   (buf_ready)
    );

    hbm_beat_splitter u_beat_splitter (
        .hbm_clk     (hbm_clk),
        .hbm_aresetn (hbm_aresetn),
        .word_valid  (buf_valid),
        .word        (buf_word),
        .word_ready  (buf_ready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wlast       (wlast),
        .wready      (wready),
        .burst_done  (burst_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_hbm_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hbm_write;
    import hbm_write_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    logic       hbm_clk;
    logic       hbm_aresetn    = 1'b0;
    logic       start          = 1'b0;
    dma_addr_t  dma_addr_a     = '0;
    dma_addr_t  dma_addr_b     = '0;
    byte_len_t  data_a_length  = '0;
    byte_len_t  data_b_length  = '0;
    hbm_addr_t  hbm_addr_b     = '0;
    burst_cnt_t a_block_bursts = '0;
    hbm_addr_t  a_stride       = '0;
    logic       dma_cmd_ready  = 1'b0;
    logic       dma_data_valid = 1'b0;
    dma_word_t  dma_data       = '0;
    logic       awready        = 1'b0;
    logic       wready         = 1'b0;

    logic       dma_cmd_valid;
    dma_addr_t  dma_cmd_address;
    byte_len_t  dma_cmd_length;
    logic       dma_data_ready;
    logic       awvalid;
    hbm_addr_t  awaddr;
    logic       wvalid;
    hbm_beat_t  wdata;
    logic       wlast;
    logic       write_done;

    // scoreboard state
    dma_addr_t  exp_cmd_addr[$];
    byte_len_t  exp_cmd_len[$];
    hbm_addr_t  exp_addr[$];
    hbm_beat_t  exp_beats[$];
    int         beats_left   = 0;
    logic       beat_odd     = 1'b0;
    int         words_owed   = 0;
    int         word_idx     = 0;
    int         done_count   = 0;
    int         jobs_done    = 0;
    logic       after_done   = 1'b0;
    logic       timed_out    = 1'b0;
    int         checks       = 0;
    int         mismatches   = 0;
    int         other_errors = 0;

    hbm_write_top uut (.*);

    initial begin
        hbm_clk = 1'b0;
        forever #5 hbm_clk = ~hbm_clk;
    end

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            mismatches = mismatches + 1;
            $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // sixteen 32-bit lanes, word index above the lane number
    function automatic dma_word_t make_word(input int idx);
        dma_word_t w;
        for (int l = 0; l < 16; l++) begin
            w[l*32 +: 32] = (idx << 8) | l;
        end
        return w;
    endfunction

    function automatic hbm_addr_t a_burst_addr(input int k, input int blk, input hbm_addr_t strd);
        hbm_addr_t chan_part;
        hbm_addr_t pass_part;
        hbm_addr_t offs_part;
        chan_part = hbm_addr_t'((k / blk) % 8) << 28;
        pass_part = hbm_addr_t'(k / (8 * blk)) * strd;
        offs_part = hbm_addr_t'((k % blk) * 64);
        return chan_part + pass_part + offs_part;
    endfunction

    ////////////////////
    // memory side and DMA models
    ////////////////////

    always @(posedge hbm_clk) begin
        awready       <= ($urandom % 4) != 0;
        wready        <= ($urandom % 3) != 0;
        dma_cmd_ready <= ($urandom % 2) != 0;
    end

    always @(posedge hbm_clk) begin
        if (!hbm_aresetn) begin
            dma_data_valid <= 1'b0;
        end else begin
            if (dma_cmd_valid && dma_cmd_ready) begin
                words_owed = words_owed + (dma_cmd_length >> 6);
            end
            // hold the word until the buffer takes it
            if (!dma_data_valid || dma_data_ready) begin
                if ((words_owed > 0) && (($urandom % 4) != 0)) begin
                    dma_data_valid <= 1'b1;
                    dma_data       <= make_word(word_idx);
                    word_idx   = word_idx + 1;
                    words_owed = words_owed - 1;
                end else begin
                    dma_data_valid <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // handshake monitor
    ////////////////////

    always @(posedge hbm_clk) begin
        if (hbm_aresetn) begin
            if (dma_cmd_valid && dma_cmd_ready) begin
                if (exp_cmd_addr.size() == 0) begin
                    other_errors = other_errors + 1;
                    $display("unexpected DMA command at %0t ns", $time);
                end else begin
                    check_value("dma_cmd_address", dma_cmd_address, exp_cmd_addr.pop_front());
                    check_value("dma_cmd_length", dma_cmd_length, exp_cmd_len.pop_front());
                end
            end
            if (dma_data_valid && dma_data_ready) begin
                exp_beats.push_back(dma_data[255:0]);
                exp_beats.push_back(dma_data[511:256]);
            end
            if (awvalid && awready) begin
                if (exp_addr.size() == 0) begin
                    other_errors = other_errors + 1;
                    $display("extra write address at %0t ns", $time);
                end else begin
                    check_value("awaddr", awaddr, exp_addr.pop_front());
                end
            end
            if (wvalid && wready) begin
                if (exp_beats.size() == 0) begin
                    other_errors = other_errors + 1;
                    $display("write beat with no DMA word behind it at %0t ns", $time);
                end else begin
                    check_value("wdata", wdata, exp_beats.pop_front());
                end
                check_value("wlast", wlast, beat_odd);
                beat_odd   = ~beat_odd;
                beats_left = beats_left - 1;
            end
            if (write_done) begin
                done_count = done_count + 1;
                check_value("addresses left at write_done", exp_addr.size(), 0);
                check_value("beats left at write_done", beats_left, 0);
                after_done <= 1'b1;
            end
        end
    end

    a_done_pulse: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        write_done |=> !write_done)
        else begin
            other_errors = other_errors + 1;
            $display("write_done stayed high for more than one cycle at %0t ns", $time);
        end

    a_quiet_after_done: assert property (@(posedge hbm_clk) disable iff (!hbm_aresetn)
        after_done |-> (!awvalid && !wvalid))
        else begin
            other_errors = other_errors + 1;
            $display("write channel active after write_done at %0t ns", $time);
        end

    ////////////////////
    // jobs
    ////////////////////

    task automatic run_job(input int b_bursts, input int a_bursts, input int blk,
                           input hbm_addr_t strd, input hbm_addr_t hbm_b,
                           input dma_addr_t dma_a, input dma_addr_t dma_b);
        int cycles;
        exp_cmd_addr.push_back(dma_b);
        exp_cmd_len.push_back(b_bursts * 64);
        exp_cmd_addr.push_back(dma_a);
        exp_cmd_len.push_back(a_bursts * 64);
        for (int k = 0; k < b_bursts; k++) begin
            exp_addr.push_back(hbm_b + hbm_addr_t'(k * 64));
        end
        for (int k = 0; k < a_bursts; k++) begin
            exp_addr.push_back(a_burst_addr(k, blk, strd));
        end
        beats_left = 2 * (a_bursts + b_bursts);
        @(posedge hbm_clk);
        start          <= 1'b1;
        dma_addr_a     <= dma_a;
        dma_addr_b     <= dma_b;
        data_a_length  <= a_bursts * 64;
        data_b_length  <= b_bursts * 64;
        hbm_addr_b     <= hbm_b;
        a_block_bursts <= blk;
        a_stride       <= strd;
        after_done     <= 1'b0;
        @(posedge hbm_clk);
        start <= 1'b0;
        cycles = 0;
        while ((done_count == jobs_done) && (cycles < TIMEOUT_CYCLES)) begin
            @(posedge hbm_clk);
            cycles = cycles + 1;
        end
        if (done_count == jobs_done) begin
            other_errors = other_errors + 1;
            timed_out    = 1'b1;
            $display("timed out waiting for write_done of job %0d", jobs_done + 1);
        end else begin
            jobs_done = jobs_done + 1;
            // idle gap so a second done pulse would be counted
            repeat (10) @(posedge hbm_clk);
            check_value("write_done count", done_count, jobs_done);
        end
    endtask

    task automatic finish_run;
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if ((mismatches == 0) && (other_errors == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(96273));
        repeat (2) @(posedge hbm_clk);
        @(negedge hbm_clk);
        check_value("dma_cmd_valid", dma_cmd_valid, 0);
        check_value("awvalid", awvalid, 0);
        check_value("wvalid", wvalid, 0);
        check_value("write_done", write_done, 0);
        check_value("buffer out_valid", uut.u_word_buffer.out_valid, 0);
        check_value("dma_data_ready", dma_data_ready, 1);
        @(posedge hbm_clk);
        hbm_aresetn <= 1'b1;
        run_job(4, 8, 1, 33'h0_0000_1000, 33'h0_1234_0000,
                64'h0000_0001_0000_0000, 64'h0000_0002_0000_0000);
        if (!timed_out) begin
            run_job(20, 40, 2, 33'h0_0000_0400, 33'h1_0000_0040,
                    64'h0000_00a0_0000_1000, 64'h0000_00b0_0000_2000);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/hbm_write_pkg.sv
logic/hbm_word_buffer.sv
logic/hbm_beat_splitter.sv
logic/hbm_addr_gen.sv
logic/hbm_write_ctrl.sv
logic/hbm_write_top.sv
testbench/tb_hbm_write.sv
